/* adder.sv */
// Ripple-carry adder with carry in and carry out
`timescale 1ns/100ps

module adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             carry_in,
  output logic [WIDTH-1:0] sum,
  output logic             carry_out
);

  // Carry chain, bit 0 is the incoming carry and the top bit leaves the adder
  logic [WIDTH:0] carry;

  assign carry[0] = carry_in;

  // One full adder per bit, each taking the carry of the bit below
  for (genvar i = 0; i < WIDTH; i++) begin : g_bit
    assign sum[i]       = a[i] ^ b[i] ^ carry[i];
    assign carry[i + 1] = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
  end

  assign carry_out = carry[WIDTH];

endmodule

/* alu.sv */
// ALU with opcode decode, aligned result pipeline, flag generation and credit-based issue
`timescale 1ns/100ps

module alu #(
  parameter int WIDTH       = exec_pkg::DEF_WIDTH,
  parameter int MUL_STAGES  = exec_pkg::DEF_MUL_STAGES,
  parameter int QUEUE_DEPTH = exec_pkg::DEF_QUEUE_DEPTH
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  exec_pkg::alu_req_t           req,
  input  logic                         req_valid,
  output logic                         req_ready,
  input  logic [$clog2(QUEUE_DEPTH):0] free_slots,
  output exec_pkg::alu_rsp_t           push_rsp,
  output logic                         push_valid
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

  // Adder outcome and request context, delayed to line up with the multiplier
  typedef struct packed {
    exec_pkg::alu_op_e          op;
    logic [exec_pkg::TAG_W-1:0] tag;
    logic [WIDTH-1:0]           sum;
    logic                       carry;
    logic                       lt;
  } stage_t;

  logic                  subtract;
  logic [WIDTH-1:0]      op_a;
  logic [WIDTH-1:0]      op_b;
  logic [WIDTH-1:0]      sum;
  logic                  carry_out;
  logic                  overflow;
  logic                  accept;
  logic [WIDTH-1:0]      product;
  stage_t                stage_d;
  stage_t                stage_q [MUL_STAGES];
  logic [MUL_STAGES-1:0] stage_vld;
  stage_t                last;
  logic [WIDTH-1:0]      result;
  exec_pkg::alu_rsp_t    rsp_d;
  logic [CNT_W-1:0]      in_flight;

  // Subtract and compare both need a - b, done as a + ~b + 1
  assign subtract = (req.op == exec_pkg::OP_SUB) || (req.op == exec_pkg::OP_SLT);
  assign op_a     = req.a[WIDTH-1:0];
  assign op_b     = subtract ? ~req.b[WIDTH-1:0] : req.b[WIDTH-1:0];

  adder #(
    .WIDTH(WIDTH)
  ) i_adder (
    .a        (op_a),
    .b        (op_b),
    .carry_in (subtract),
    .sum      (sum),
    .carry_out(carry_out)
  );

  // Fed every cycle; the product is only used when the opcode says so
  multiplier #(
    .WIDTH     (WIDTH),
    .MUL_STAGES(MUL_STAGES)
  ) i_multiplier (
    .clk         (clk),
    .rst_n       (rst_n),
    .multiplicand(op_a),
    .multiplier  (req.b[WIDTH-1:0]),
    .product     (product)
  );

  // Signed overflow of a + op_b, needed to get the true sign of a - b
  assign overflow = (op_a[WIDTH-1] == op_b[WIDTH-1]) && (sum[WIDTH-1] != op_a[WIDTH-1]);

  always_comb
  begin
    stage_d.op    = req.op;
    stage_d.tag   = req.tag;
    stage_d.sum   = sum;
    stage_d.carry = carry_out;
    // a < b signed when the difference is negative, unless it overflowed
    stage_d.lt    = sum[WIDTH-1] ^ overflow;
  end

  // Credits: never take more than the queue can absorb, counting what is in flight
  assign req_ready = in_flight < free_slots;
  assign accept    = req_valid && req_ready;

  // Valid bits of the delay line
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      stage_vld <= '0;
    else
    begin
      stage_vld[0] <= accept;
      for (int s = 1; s < MUL_STAGES; s++)
        stage_vld[s] <= stage_vld[s-1];
    end
  end

  // Payload of the delay line
  always_ff @(posedge clk)
  begin
    stage_q[0] <= stage_d;
    for (int s = 1; s < MUL_STAGES; s++)
      stage_q[s] <= stage_q[s-1];
  end

  assign last = stage_q[MUL_STAGES-1];

  // The last stage and the multiplier output belong to the same request
  always_comb
  begin
    case (last.op)
      exec_pkg::OP_MUL: result = product;
      exec_pkg::OP_SLT: result = {{(WIDTH-1){1'b0}}, last.lt};
      default:          result = last.sum;
    endcase
    rsp_d.result = 32'(result);
    rsp_d.zero   = (result == '0);
    rsp_d.carry  = ((last.op == exec_pkg::OP_ADD) || (last.op == exec_pkg::OP_SUB)) ?
                   last.carry : 1'b0;
    rsp_d.tag    = last.tag;
  end

  // Output register, one edge ahead of the queue write
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      push_valid <= 1'b0;
    else
      push_valid <= stage_vld[MUL_STAGES-1];
  end

  always_ff @(posedge clk)
  begin
    push_rsp <= rsp_d;
  end

  // In-flight count of accepted requests not yet written into the queue
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      in_flight <= '0;
    else
    begin
      case ({accept, push_valid})
        2'b10:   in_flight <= in_flight + CNT_W'(1);
        2'b01:   in_flight <= in_flight - CNT_W'(1);
        default: in_flight <= in_flight;
      endcase
    end
  end

  // A push must always find a free slot in the queue
  a_push_has_room: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid |-> free_slots != '0)
    else $error("push without a free queue slot");

  // Credits never exceed what the queue can hold
  a_in_flight_max: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight <= CNT_W'(QUEUE_DEPTH))
    else $error("in-flight count above queue depth");

endmodule

/* exec_pkg.sv */
// Opcode enum, request and response structs, tag width and default parameters of the execution unit
package exec_pkg;

  // Tags are carried through the unit untouched, so their width is fixed here
  localparam int TAG_W = 4;

  // Defaults picked up by the top level when no override is given
  localparam int DEF_WIDTH       = 32;
  localparam int DEF_MUL_STAGES  = 3;
  localparam int DEF_QUEUE_DEPTH = 8;

  // Integer operations handled by the ALU
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10,
    OP_SLT = 2'b11
  } alu_op_e;

  // One operation request from the issue side
  typedef struct packed {
    alu_op_e          op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [TAG_W-1:0] tag;
  } alu_req_t;

  // One completed operation with its flags
  // Carry is meaningful only for add and subtract and reads 0 otherwise
  typedef struct packed {
    logic [31:0]      result;
    logic             zero;
    logic             carry;
    logic [TAG_W-1:0] tag;
  } alu_rsp_t;

endpackage

/* exec_unit.sv */
// Execution unit top level joining the ALU and the result queue
`timescale 1ns/100ps

module exec_unit #(
  parameter int WIDTH       = exec_pkg::DEF_WIDTH,
  parameter int MUL_STAGES  = exec_pkg::DEF_MUL_STAGES,
  parameter int QUEUE_DEPTH = exec_pkg::DEF_QUEUE_DEPTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  exec_pkg::alu_req_t req,
  input  logic               req_valid,
  output logic               req_ready,
  output exec_pkg::alu_rsp_t rsp,
  output logic               rsp_valid,
  input  logic               rsp_ready
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

  // Results leaving the ALU pipeline
  exec_pkg::alu_rsp_t push_rsp;
  logic               push_valid;
  // Room left in the queue, used as issue credit by the ALU
  logic [CNT_W-1:0]   free_slots;

  alu #(
    .WIDTH      (WIDTH),
    .MUL_STAGES (MUL_STAGES),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .free_slots(free_slots),
    .push_rsp  (push_rsp),
    .push_valid(push_valid)
  );

  result_queue #(
    .DEPTH(QUEUE_DEPTH)
  ) i_result_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_rsp  (push_rsp),
    .push_valid(push_valid),
    .free_slots(free_slots),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

endmodule

/* multiplier.sv */
// Pipelined unsigned multiplier that keeps the low half of the product
`timescale 1ns/100ps

module multiplier #(
  parameter int WIDTH      = 32,
  parameter int MUL_STAGES = 3
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] multiplicand,
  input  logic [WIDTH-1:0] multiplier,
  output logic [WIDTH-1:0] product
);

  // The multiplier operand is cut into one slice per stage plus a final slice
  // that is added on the way out of the last register
  localparam int NSLICE = MUL_STAGES + 1;
  localparam int SLICE  = (WIDTH + NSLICE - 1) / NSLICE;
  localparam int EXT_W  = SLICE * NSLICE;

  // Operands travel with the running sum so a new pair can enter every cycle
  typedef struct packed {
    logic [WIDTH-1:0] mcand;
    logic [EXT_W-1:0] mplier;
  } opnd_t;

  opnd_t            opnd_q [MUL_STAGES];
  logic [WIDTH-1:0] acc_q  [MUL_STAGES];
  opnd_t            opnd_in;

  // Partial product of one slice, already shifted to its weight
  // Bits above WIDTH are dropped since only the low half is kept
  function automatic logic [WIDTH-1:0] partial(input opnd_t opnd, input int k);
    logic [WIDTH-1:0] digit;
    digit = WIDTH'(opnd.mplier[k*SLICE +: SLICE]);
    return (opnd.mcand * digit) << (k * SLICE);
  endfunction

  // Zero-extend the multiplier so every slice has full width
  always_comb
  begin
    opnd_in.mcand  = multiplicand;
    opnd_in.mplier = EXT_W'(multiplier);
  end

  // Running sums, cleared on reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int s = 0; s < MUL_STAGES; s++)
        acc_q[s] <= '0;
    end
    else
    begin
      acc_q[0] <= partial(opnd_in, 0);
      for (int s = 1; s < MUL_STAGES; s++)
        acc_q[s] <= acc_q[s-1] + partial(opnd_q[s-1], s);
    end
  end

  // Operand copies follow the running sum down the pipe
  always_ff @(posedge clk)
  begin
    opnd_q[0] <= opnd_in;
    for (int s = 1; s < MUL_STAGES; s++)
      opnd_q[s] <= opnd_q[s-1];
  end

  // The top slice is folded in after the last register
  assign product = acc_q[MUL_STAGES-1] + partial(opnd_q[MUL_STAGES-1], MUL_STAGES);

endmodule

/* result_queue.sv */
// Response FIFO with valid/ready output and free-slot count
`timescale 1ns/100ps

module result_queue #(
  parameter int DEPTH = exec_pkg::DEF_QUEUE_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  exec_pkg::alu_rsp_t     push_rsp,
  input  logic                   push_valid,
  output logic [$clog2(DEPTH):0] free_slots,
  output exec_pkg::alu_rsp_t     rsp,
  output logic                   rsp_valid,
  input  logic                   rsp_ready
);

  localparam int CNT_W = $clog2(DEPTH) + 1;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  exec_pkg::alu_rsp_t mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               pop;

  // Pointers wrap by hand so the depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign pop        = rsp_valid && rsp_ready;
  assign rsp_valid  = count != '0;
  assign rsp        = mem[rd_ptr];
  assign free_slots = CNT_W'(DEPTH) - count;

  // Storage
  always_ff @(posedge clk)
  begin
    if (push_valid)
      mem[wr_ptr] <= push_rsp;
  end

  // Pointers and occupancy, push and pop may share a cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push_valid, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // The ALU credit scheme keeps writes away from a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_valid |-> count != CNT_W'(DEPTH))
    else $error("push into a full queue");

  // A stalled head item stays put until the consumer takes it
  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("head response changed while stalled");

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; a $fatal gives a non-zero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f vlog.f --top-module tb_exec_unit -o sim_exec_unit &&
./obj_dir/sim_exec_unit || exit 1

/* tb_exec_unit.sv */
// Testbench for the execution unit with reference model, scoreboard, timeout and directed tests
`timescale 1ns/100ps

module tb_exec_unit;

  localparam int WIDTH          = exec_pkg::DEF_WIDTH;
  localparam int MUL_STAGES     = exec_pkg::DEF_MUL_STAGES;
  localparam int QUEUE_DEPTH    = exec_pkg::DEF_QUEUE_DEPTH;
  // Roughly four times the cycles that all tests together need
  localparam int TIMEOUT_CYCLES = 5000;
  // At most a full queue is outstanding, each item needs the pipe latency plus one pop
  localparam int DRAIN_CYCLES   = 2 * (QUEUE_DEPTH + MUL_STAGES + 2);

  logic               clk;
  logic               rst_n;
  exec_pkg::alu_req_t req;
  logic               req_valid;
  logic               req_ready;
  exec_pkg::alu_rsp_t rsp;
  logic               rsp_valid;
  logic               rsp_ready;

  // Scoreboard of expected responses in issue order
  exec_pkg::alu_rsp_t         exp_q [$];
  int                         n_issued;
  int                         n_matched;
  int                         cycles;
  logic [exec_pkg::TAG_W-1:0] next_tag;
  string                      test_name;

  exec_unit #(
    .WIDTH      (WIDTH),
    .MUL_STAGES (MUL_STAGES),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_exec_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .rsp      (rsp),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready)
  );

  always #20 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s %s expected %0h actual %0h", test_name, what, expected, actual);
      fail_run("value mismatch");
    end
  endtask

  // Expected response built from the opcode rules
  function automatic exec_pkg::alu_rsp_t ref_rsp(input exec_pkg::alu_req_t r);
    exec_pkg::alu_rsp_t e;
    logic [32:0]        wide;
    logic [63:0]        prod;
    e.carry = 1'b0;
    case (r.op)
      exec_pkg::OP_ADD:
      begin
        wide     = {1'b0, r.a} + {1'b0, r.b};
        e.result = wide[31:0];
        e.carry  = wide[32];
      end
      exec_pkg::OP_SUB:
      begin
        // Carry means no borrow, so it is set when a is not below b unsigned
        e.result = r.a - r.b;
        e.carry  = (r.a >= r.b);
      end
      exec_pkg::OP_MUL:
      begin
        prod     = {32'd0, r.a} * {32'd0, r.b};
        e.result = prod[31:0];
      end
      default:
        e.result = ($signed(r.a) < $signed(r.b)) ? 32'd1 : 32'd0;
    endcase
    e.zero = (e.result == 32'd0);
    e.tag  = r.tag;
    return e;
  endfunction

  // Every request gets the next tag in sequence
  task automatic build_req(input exec_pkg::alu_op_e op, input logic [31:0] a,
                           input logic [31:0] b, output exec_pkg::alu_req_t r);
    r.op     = op;
    r.a      = a;
    r.b      = b;
    r.tag    = next_tag;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic random_req(output exec_pkg::alu_req_t r);
    build_req(exec_pkg::alu_op_e'(2'($urandom_range(3))), $urandom, $urandom, r);
  endtask

  // Offers one request and returns on the edge where it is taken
  task automatic send_op(input exec_pkg::alu_op_e op, input logic [31:0] a,
                         input logic [31:0] b);
    exec_pkg::alu_req_t r;
    build_req(op, a, b, r);
    req       <= r;
    req_valid <= 1'b1;
    do @(posedge clk); while (!req_ready);
    req_valid <= 1'b0;
  endtask

  // Random traffic where an offered request stays valid until it is taken
  task automatic drive_traffic(input int n, input int valid_pct, input int ready_pct,
                               output int edges);
    exec_pkg::alu_req_t r;
    int                 sent;
    bit                 pending;
    sent    = 0;
    pending = 1'b0;
    edges   = 0;
    while (sent < n)
    begin
      if (!pending && (int'($urandom_range(99)) < valid_pct))
      begin
        random_req(r);
        req     <= r;
        pending  = 1'b1;
      end
      req_valid <= pending;
      rsp_ready <= (int'($urandom_range(99)) < ready_pct);
      @(posedge clk);
      edges++;
      if (pending && req_ready)
      begin
        pending = 1'b0;
        sent++;
      end
    end
    req_valid <= 1'b0;
    rsp_ready <= 1'b1;
  endtask

  // Gives the outstanding responses a bounded time to arrive, then checks that all did
  // Counters are read on the falling edge, after the scoreboard has updated them
  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while ((n_matched != n_issued) && (waited < DRAIN_CYCLES))
    begin
      @(negedge clk);
      waited++;
    end
    check_value("responses drained", 64'(n_issued), 64'(n_matched));
    @(posedge clk);
  endtask

  task automatic check_reset_state();
    test_name = "reset_state";
    @(posedge clk);
    check_value("rsp_valid", 64'(1'b0), 64'(rsp_valid));
    check_value("req_ready", 64'(1'b1), 64'(req_ready));
  endtask

  task automatic corner_operations();
    test_name = "corner_operations";
    send_op(exec_pkg::OP_ADD, 32'h0000_0000, 32'h0000_0000);
    send_op(exec_pkg::OP_ADD, 32'hffff_ffff, 32'h0000_0001);
    send_op(exec_pkg::OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
    send_op(exec_pkg::OP_ADD, 32'hffff_ffff, 32'hffff_ffff);
    send_op(exec_pkg::OP_SUB, 32'h0000_0005, 32'h0000_0005);
    send_op(exec_pkg::OP_SUB, 32'h0000_0000, 32'h0000_0001);
    send_op(exec_pkg::OP_SUB, 32'h8000_0000, 32'h0000_0001);
    send_op(exec_pkg::OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
    send_op(exec_pkg::OP_MUL, 32'h0000_0000, 32'h0000_1234);
    send_op(exec_pkg::OP_MUL, 32'h0001_0000, 32'h0001_0000);
    send_op(exec_pkg::OP_SLT, 32'h0000_0005, 32'h0000_0005);
    send_op(exec_pkg::OP_SLT, 32'hffff_ffff, 32'h0000_0001);
    send_op(exec_pkg::OP_SLT, 32'h0000_0001, 32'hffff_ffff);
    // These two overflow in the subtraction
    send_op(exec_pkg::OP_SLT, 32'h8000_0000, 32'h7fff_ffff);
    send_op(exec_pkg::OP_SLT, 32'h7fff_ffff, 32'h8000_0000);
    drain();
  endtask

  task automatic back_to_back_stream();
    int edges;
    test_name = "back_to_back_stream";
    drive_traffic(64, 100, 100, edges);
    check_value("edges for 64 requests", 64'(64), 64'(edges));
    drain();
  endtask

  task automatic back_pressure();
    exec_pkg::alu_req_t r;
    int                 start;
    test_name  = "back_pressure";
    start      = n_issued;
    rsp_ready <= 1'b0;
    random_req(r);
    req       <= r;
    req_valid <= 1'b1;
    repeat (4 * QUEUE_DEPTH + MUL_STAGES)
    begin
      @(posedge clk);
      if (req_ready)
      begin
        random_req(r);
        req <= r;
      end
    end
    check_value("accepted while stalled", 64'(QUEUE_DEPTH), 64'(n_issued - start));
    check_value("req_ready while full", 64'(1'b0), 64'(req_ready));
    // The request still on offer is taken once the consumer drains the queue
    rsp_ready <= 1'b1;
    do @(posedge clk); while (!req_ready);
    req_valid <= 1'b0;
    drain();
  endtask

  task automatic random_handshakes();
    int edges;
    test_name = "random_handshakes";
    drive_traffic(200, 50, 50, edges);
    drain();
  endtask

  // Scoreboard records accepted requests and checks every popped response
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (req_valid && req_ready)
      begin
        exp_q.push_back(ref_rsp(req));
        n_issued++;
      end
      if (rsp_valid && rsp_ready)
      begin
        if (exp_q.size() == 0)
          fail_run("response arrived with no request outstanding");
        else
        begin
          check_value("response", 64'(exp_q.pop_front()), 64'(rsp));
          n_matched++;
        end
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
      fail_run($sformatf("timeout after %0d cycles with the DUT not done", cycles));
  end

  initial
  begin
    void'($urandom(72810));
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    n_issued  = 0;
    n_matched = 0;
    cycles    = 0;
    next_tag  = '0;
    test_name = "reset";
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    corner_operations();
    back_to_back_stream();
    back_pressure();
    random_handshakes();
    if (exp_q.size() == 0 && n_issued == n_matched)
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
      fail_run("responses still missing at the end of the run");
  end

endmodule

/* vlog.f */
exec_pkg.sv
adder.sv
multiplier.sv
alu.sv
result_queue.sv
exec_unit.sv
tb_exec_unit.sv
